/* design/oooPkg.sv */
package oooPkg;

    localparam int QUEUE_SIZE = 8;
    localparam int ROB_SIZE = 16;
    localparam int SQN_BITS = 6;
    localparam int MUL_LATENCY = 3;

    localparam logic [5:0] OP_ADD = 6'h01;
    localparam logic [5:0] OP_SUB = 6'h02;
    localparam logic [5:0] OP_AND = 6'h03;
    localparam logic [5:0] OP_XOR = 6'h04;
    localparam logic [5:0] OP_ADDI = 6'h05;
    localparam logic [5:0] OP_MUL = 6'h06;

    // Sequence number doubles as the result tag
    typedef logic [SQN_BITS-1:0] SqN;
    typedef logic [4:0] RegNm;

    typedef logic [$clog2(QUEUE_SIZE)-1:0] QueueIdx;
    typedef logic [$clog2(QUEUE_SIZE):0] QueueCnt;
    typedef logic [$clog2(ROB_SIZE)-1:0] RobIdx;
    typedef logic [$clog2(ROB_SIZE):0] RobCnt;

    typedef enum logic {
        FU_ALU,
        FU_MUL
    } FuncUnit;

    // Opcode sits in the same bits in both views
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            RegNm rd;
            RegNm rs1;
            RegNm rs2;
            logic [10:0] unused;
        } rType;
        struct packed {
            logic [5:0] opcode;
            RegNm rd;
            RegNm rs1;
            logic [15:0] imm;
        } iType;
    } InstWord;

    typedef struct packed {
        logic avail;
        SqN tag;
        logic [31:0] value;
    } Operand;

    typedef struct packed {
        SqN sqN;
        RegNm nmDst;
        logic [5:0] opcode;
        FuncUnit fu;
        Operand opA;
        Operand opB;
    } Uop;

    typedef struct packed {
        logic valid;
        SqN tag;
        RegNm nmDst;
        logic [31:0] value;
    } ResultBus;

    typedef struct packed {
        SqN sqN;
        RegNm nmDst;
        logic [31:0] value;
    } Commit;

    // Capture a waiting operand when its tag is on the result bus
    function automatic Operand wakeOperand(Operand op, ResultBus res);
        Operand woken;
        woken = op;
        if (!op.avail && res.valid && res.tag == op.tag) begin
            woken.avail = 1'b1;
            woken.value = res.value;
        end
        return woken;
    endfunction

endpackage

/* design/uopDecoder.sv */
`timescale 1ns/1ps

module uopDecoder import oooPkg::*; (
    input logic clk,
    input logic rst,
    input logic instValid,
    input InstWord instWord,
    input logic queueFull,
    input logic robFull,
    input ResultBus result,
    output logic instReady,
    output logic uopValid,
    output Uop uop,
    output logic allocValid,
    output SqN allocSqN
);

    // Rename table
    logic pending [32];
    SqN regTag [32];
    logic [31:0] regValue [32];

    SqN nextSqN;
    logic isImm;
    logic accept;
    Uop newUop;

    function automatic Operand readOperand(RegNm nm);
        Operand op;
        op.avail = !pending[nm];
        op.tag = regTag[nm];
        op.value = regValue[nm];
        // Bypass a result broadcast in this cycle
        return wakeOperand(op, result);
    endfunction

    assign instReady = !robFull && !(uopValid && queueFull);
    assign accept = instValid && instReady;
    assign allocValid = accept;
    assign allocSqN = nextSqN;

    always_comb begin
        isImm = instWord.rType.opcode == OP_ADDI;
        newUop.sqN = nextSqN;
        newUop.opcode = instWord.rType.opcode;
        newUop.fu = (instWord.rType.opcode == OP_MUL) ? FU_MUL : FU_ALU;
        if (isImm) begin
            newUop.nmDst = instWord.iType.rd;
            newUop.opA = readOperand(instWord.iType.rs1);
            newUop.opB.avail = 1'b1;
            newUop.opB.tag = '0;
            newUop.opB.value = {{16{instWord.iType.imm[15]}}, instWord.iType.imm};
        end else begin
            newUop.nmDst = instWord.rType.rd;
            newUop.opA = readOperand(instWord.rType.rs1);
            newUop.opB = readOperand(instWord.rType.rs2);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uopValid <= 1'b0;
            nextSqN <= '0;
            for (int i = 0; i < 32; i++) begin
                pending[i] <= 1'b0;
                regValue[i] <= '0;
            end
        end else begin
            if (result.valid && pending[result.nmDst] && regTag[result.nmDst] == result.tag) begin
                pending[result.nmDst] <= 1'b0;
                regValue[result.nmDst] <= result.value;
            end
            if (accept) begin
                uopValid <= 1'b1;
                uop <= newUop;
                nextSqN <= nextSqN + SqN'(1);
                // Newer producer overrides the table update above
                if (newUop.nmDst != '0) begin
                    pending[newUop.nmDst] <= 1'b1;
                    regTag[newUop.nmDst] <= nextSqN;
                end
            end else begin
                if (!queueFull) begin
                    uopValid <= 1'b0;
                end
                // Held op must not miss a broadcast
                uop.opA <= wakeOperand(uop.opA, result);
                uop.opB <= wakeOperand(uop.opB, result);
            end
        end
    end

endmodule

/* design/issueQueue.sv */
`timescale 1ns/1ps

module issueQueue import oooPkg::*; (
    input logic clk,
    input logic rst,
    input logic uopValid,
    input Uop uop,
    input ResultBus result,
    output logic queueFull,
    output logic issueValid,
    output Uop issueUop
);

    // Entries kept oldest first
    Uop entries [QUEUE_SIZE];
    Uop woken [QUEUE_SIZE];
    Uop incoming;
    QueueCnt insertIndex;

    // Bit 0 set means the next issued op would collide with a multiply
    logic [MUL_LATENCY-2:0] reservedWb;

    logic found;
    QueueIdx sel;
    logic insert;
    QueueIdx insertPos;

    always_comb begin
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            woken[i] = entries[i];
            woken[i].opA = wakeOperand(entries[i].opA, result);
            woken[i].opB = wakeOperand(entries[i].opB, result);
        end
    end

    always_comb begin
        incoming = uop;
        incoming.opA = wakeOperand(uop.opA, result);
        incoming.opB = wakeOperand(uop.opB, result);
    end

    // Oldest ready entry wins
    always_comb begin
        found = 1'b0;
        sel = '0;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            if (!found && QueueCnt'(i) < insertIndex &&
                woken[i].opA.avail && woken[i].opB.avail &&
                !(woken[i].fu == FU_ALU && reservedWb[0])) begin
                found = 1'b1;
                sel = QueueIdx'(i);
            end
        end
    end

    assign queueFull = int'(insertIndex) + int'(uopValid) > QUEUE_SIZE;
    assign insert = uopValid && !queueFull;
    assign insertPos = QueueIdx'(insertIndex - QueueCnt'(found));

    always_ff @(posedge clk) begin
        // Collapse younger entries over the issued one
        for (int i = 0; i < QUEUE_SIZE - 1; i++) begin
            if (found && QueueIdx'(i) >= sel) begin
                entries[i] <= woken[i + 1];
            end else begin
                entries[i] <= woken[i];
            end
        end
        entries[QUEUE_SIZE-1] <= woken[QUEUE_SIZE-1];

        if (insert) begin
            entries[insertPos] <= incoming;
        end

        issueUop <= woken[sel];

        if (rst) begin
            issueValid <= 1'b0;
            insertIndex <= '0;
            reservedWb <= '0;
        end else begin
            issueValid <= found;
            insertIndex <= insertIndex + QueueCnt'(insert) - QueueCnt'(found);
            reservedWb <= reservedWb >> 1;
            // Multiply result lands two issue slots later than an ALU op
            if (found && woken[sel].fu == FU_MUL) begin
                reservedWb[MUL_LATENCY-2] <= 1'b1;
            end
        end
    end

endmodule

/* design/intExecute.sv */
`timescale 1ns/1ps

module intExecute import oooPkg::*; (
    input logic clk,
    input logic rst,
    input logic issueValid,
    input Uop issueUop,
    output ResultBus exResult
);

    ResultBus aluOut;
    logic [31:0] aluValue;

    // Multiply stage 0 holds operands, later stages the product
    logic mulValid0;
    SqN mulTag0;
    RegNm mulDst0;
    logic [31:0] mulA;
    logic [31:0] mulB;
    ResultBus mulPipe [1:MUL_LATENCY-1];

    always_comb begin
        case (issueUop.opcode)
            OP_SUB: aluValue = issueUop.opA.value - issueUop.opB.value;
            OP_AND: aluValue = issueUop.opA.value & issueUop.opB.value;
            OP_XOR: aluValue = issueUop.opA.value ^ issueUop.opB.value;
            default: aluValue = issueUop.opA.value + issueUop.opB.value;
        endcase
    end

    always_ff @(posedge clk) begin
        aluOut.tag <= issueUop.sqN;
        aluOut.nmDst <= issueUop.nmDst;
        aluOut.value <= aluValue;

        mulTag0 <= issueUop.sqN;
        mulDst0 <= issueUop.nmDst;
        mulA <= issueUop.opA.value;
        mulB <= issueUop.opB.value;

        mulPipe[1].tag <= mulTag0;
        mulPipe[1].nmDst <= mulDst0;
        mulPipe[1].value <= mulA * mulB;
        for (int k = 2; k < MUL_LATENCY; k++) begin
            mulPipe[k] <= mulPipe[k-1];
        end

        if (rst) begin
            aluOut.valid <= 1'b0;
            mulValid0 <= 1'b0;
            mulPipe[1].valid <= 1'b0;
            for (int k = 2; k < MUL_LATENCY; k++) begin
                mulPipe[k].valid <= 1'b0;
            end
        end else begin
            aluOut.valid <= issueValid && issueUop.fu == FU_ALU;
            mulValid0 <= issueValid && issueUop.fu == FU_MUL;
            mulPipe[1].valid <= mulValid0;
        end
    end

    // Issue queue keeps these two from being valid together
    assign exResult = aluOut.valid ? aluOut : mulPipe[MUL_LATENCY-1];

endmodule

/* design/resultReorder.sv */
`timescale 1ns/1ps

module resultReorder import oooPkg::*; (
    input logic clk,
    input logic rst,
    input ResultBus exResult,
    input logic allocValid,
    input SqN allocSqN,
    output ResultBus result,
    output logic robFull,
    output logic commitValid,
    output Commit commitOut
);

    logic [ROB_SIZE-1:0] done;
    RegNm entryDst [ROB_SIZE];
    logic [31:0] entryValue [ROB_SIZE];

    SqN headSqN;
    RobIdx headIdx;
    RobIdx exIdx;
    RobIdx allocIdx;
    RobCnt busyCount;
    logic commitNow;

    assign headIdx = headSqN[$clog2(ROB_SIZE)-1:0];
    assign exIdx = exResult.tag[$clog2(ROB_SIZE)-1:0];
    assign allocIdx = allocSqN[$clog2(ROB_SIZE)-1:0];
    assign commitNow = done[headIdx];
    assign robFull = busyCount == RobCnt'(ROB_SIZE);

    always_ff @(posedge clk) begin
        result <= exResult;

        if (exResult.valid) begin
            entryDst[exIdx] <= exResult.nmDst;
            entryValue[exIdx] <= exResult.value;
        end

        commitOut.sqN <= headSqN;
        commitOut.nmDst <= entryDst[headIdx];
        commitOut.value <= entryValue[headIdx];

        if (rst) begin
            result.valid <= 1'b0;
            done <= '0;
            headSqN <= '0;
            busyCount <= '0;
            commitValid <= 1'b0;
        end else begin
            commitValid <= commitNow;
            if (commitNow) begin
                done[headIdx] <= 1'b0;
                headSqN <= headSqN + SqN'(1);
            end
            if (allocValid) begin
                done[allocIdx] <= 1'b0;
            end
            // Completion is never for the entry being allocated
            if (exResult.valid) begin
                done[exIdx] <= 1'b1;
            end
            busyCount <= busyCount + RobCnt'(allocValid) - RobCnt'(commitNow);
        end
    end

endmodule

/* design/oooCore.sv */
`timescale 1ns/1ps

module oooCore import oooPkg::*; (
    input logic clk,
    input logic rst,
    input logic instValid,
    input InstWord instWord,
    output logic instReady,
    output logic commitValid,
    output Commit commitOut
);

    logic uopValid;
    Uop uop;
    logic queueFull;
    logic robFull;
    logic allocValid;
    SqN allocSqN;
    logic issueValid;
    Uop issueUop;
    ResultBus exResult;
    ResultBus result;

    uopDecoder uopDecoder_i (
        .clk(clk),
        .rst(rst),
        .instValid(instValid),
        .instWord(instWord),
        .queueFull(queueFull),
        .robFull(robFull),
        .result(result),
        .instReady(instReady),
        .uopValid(uopValid),
        .uop(uop),
        .allocValid(allocValid),
        .allocSqN(allocSqN)
    );

    issueQueue issueQueue_i (
        .clk(clk),
        .rst(rst),
        .uopValid(uopValid),
        .uop(uop),
        .result(result),
        .queueFull(queueFull),
        .issueValid(issueValid),
        .issueUop(issueUop)
    );

    intExecute intExecute_i (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issueUop(issueUop),
        .exResult(exResult)
    );

    resultReorder resultReorder_i (
        .clk(clk),
        .rst(rst),
        .exResult(exResult),
        .allocValid(allocValid),
        .allocSqN(allocSqN),
        .result(result),
        .robFull(robFull),
        .commitValid(commitValid),
        .commitOut(commitOut)
    );

endmodule

/* tests/oooCoreTb.sv */
`timescale 1ns/1ps

module oooCoreTb import oooPkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int TOTAL_INSTS = 357;
    localparam int MAX_CYCLES = 20 * TOTAL_INSTS + RESET_CYCLES;
    localparam int DRAIN_LIMIT = 200;
    localparam logic [5:0] OPCODES [6] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_MUL};

    logic clk;
    logic rst;
    logic instValid;
    InstWord instWord;
    logic instReady;
    logic commitValid;
    Commit commitOut;

    // Architectural register model and expected commits
    logic [31:0] regs [32];
    Commit expected [$];
    Commit expCommit;
    SqN nextSqN;
    string curTest;
    logic sawStall;
    int errors;
    int failures;
    int cycles;

    oooCore oooCore_i (
        .clk(clk),
        .rst(rst),
        .instValid(instValid),
        .instWord(instWord),
        .instReady(instReady),
        .commitValid(commitValid),
        .commitOut(commitOut)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] modelAlu(logic [5:0] op, logic [31:0] a, logic [31:0] b);
        case (op)
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_XOR: return a ^ b;
            OP_MUL: return a * b;
            default: return a + b;
        endcase
    endfunction

    task automatic checkValue(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", curTest, what, exp, act);
        end
    endtask

    // Holds the word until accepted, then updates the model
    task automatic sendInst(input logic [5:0] op, input RegNm rd, input RegNm rs1,
                            input RegNm rs2, input logic [15:0] imm);
        InstWord w;
        Commit exp;
        logic [31:0] b;
        if (op == OP_ADDI) begin
            w.iType.opcode = op;
            w.iType.rd = rd;
            w.iType.rs1 = rs1;
            w.iType.imm = imm;
            b = {{16{imm[15]}}, imm};
        end else begin
            w.rType.opcode = op;
            w.rType.rd = rd;
            w.rType.rs1 = rs1;
            w.rType.rs2 = rs2;
            w.rType.unused = '0;
            b = regs[rs2];
        end
        instWord = w;
        instValid = 1'b1;
        while (!instReady) begin
            sawStall = 1'b1;
            @(negedge clk);
        end
        exp.sqN = nextSqN;
        exp.nmDst = rd;
        exp.value = modelAlu(op, regs[rs1], b);
        expected.push_back(exp);
        if (rd != '0) begin
            regs[rd] = exp.value;
        end
        nextSqN++;
        @(negedge clk);
    endtask

    task automatic drainCommits();
        int waited;
        instValid = 1'b0;
        waited = 0;
        while (expected.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (expected.size() != 0) begin
            $display("%s: %0d commits never arrived", curTest, expected.size());
            failures++;
            expected.delete();
        end
    endtask

    always @(negedge clk) begin
        if (commitValid) begin
            if (expected.size() == 0) begin
                $display("%s: commit of sqN %0d with nothing outstanding", curTest,
                         commitOut.sqN);
                failures++;
            end else begin
                expCommit = expected.pop_front();
                checkValue("sqN", 32'(expCommit.sqN), 32'(commitOut.sqN));
                checkValue("nmDst", 32'(expCommit.nmDst), 32'(commitOut.nmDst));
                checkValue("value", expCommit.value, commitOut.value);
            end
        end
    end

    task automatic resetIdle();
        curTest = "resetIdle";
        repeat (10) begin
            checkValue("commitValid", 32'd0, 32'(commitValid));
            checkValue("instReady", 32'd1, 32'(instReady));
            @(negedge clk);
        end
    endtask

    task automatic independentAlu();
        curTest = "independentAlu";
        sendInst(OP_ADDI, 1, 0, 0, 16'd100);
        sendInst(OP_ADDI, 2, 0, 0, 16'hfff9);
        sendInst(OP_ADDI, 0, 0, 0, 16'd55);
        // Reads back register zero after the write above
        sendInst(OP_ADD, 4, 0, 0, '0);
        sendInst(OP_ADDI, 3, 0, 0, 16'h1234);
        sendInst(OP_ADDI, 6, 0, 0, 16'h8000);
        sendInst(OP_SUB, 7, 1, 2, '0);
        sendInst(OP_AND, 5, 1, 3, '0);
        drainCommits();
    endtask

    task automatic dependentChain();
        curTest = "dependentChain";
        sendInst(OP_ADDI, 1, 0, 0, 16'h0055);
        sendInst(OP_ADDI, 2, 1, 0, 16'd3);
        sendInst(OP_SUB, 3, 2, 1, '0);
        sendInst(OP_XOR, 4, 3, 2, '0);
        sendInst(OP_AND, 5, 4, 2, '0);
        sendInst(OP_ADD, 6, 5, 3, '0);
        sendInst(OP_ADDI, 7, 6, 0, 16'hffff);
        sendInst(OP_ADD, 1, 7, 7, '0);
        drainCommits();
    endtask

    task automatic mulInterleave();
        curTest = "mulInterleave";
        sendInst(OP_ADDI, 1, 0, 0, 16'd7);
        sendInst(OP_ADDI, 2, 0, 0, 16'hfff7);
        for (int k = 0; k < 5; k++) begin
            sendInst(OP_MUL, RegNm'(3 + k % 2), 1, 2, '0);
            sendInst(OP_ADDI, 5, 0, 0, 16'(k));
            sendInst(OP_XOR, 6, 1, 2, '0);
        end
        drainCommits();
    endtask

    task automatic mulChainFill();
        curTest = "mulChainFill";
        sawStall = 1'b0;
        sendInst(OP_ADDI, 2, 0, 0, 16'd3);
        sendInst(OP_ADDI, 1, 0, 0, 16'd1);
        repeat (22) begin
            sendInst(OP_MUL, 1, 1, 2, '0);
        end
        if (!sawStall) begin
            $display("%s: instReady never dropped during the multiply chain", curTest);
            failures++;
        end
        drainCommits();
    endtask

    task automatic randomProgram();
        int pick;
        curTest = "randomProgram";
        repeat (300) begin
            pick = $urandom % 6;
            sendInst(OPCODES[pick], RegNm'($urandom % 8), RegNm'($urandom % 8),
                     RegNm'($urandom % 8), 16'($urandom));
            // Occasional bubble in the input stream
            if ($urandom % 5 == 0) begin
                instValid = 1'b0;
                @(negedge clk);
            end
        end
        drainCommits();
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d commits outstanding", cycles,
                 expected.size());
        $display("Errors: %0d value mismatches, %0d other failures", errors, failures + 1);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        instValid = 1'b0;
        instWord = '0;
        errors = 0;
        failures = 0;
        nextSqN = '0;
        sawStall = 1'b0;
        curTest = "reset";
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        void'($urandom(32'hdd5e));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        resetIdle();
        independentAlu();
        dependentChain();
        mulInterleave();
        mulChainFill();
        randomProgram();

        $display("Errors: %0d value mismatches, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
design/oooPkg.sv
design/uopDecoder.sv
design/issueQueue.sv
design/intExecute.sv
design/resultReorder.sv
design/oooCore.sv
tests/oooCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= oooCoreTb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
